// File: design/serial_soc_params.svh
/*
 * Serial SoC address map and sizes.
 * Regions are selected by byte address bits 11:10.
 */
`ifndef SERIAL_SOC_PARAMS_SVH
`define SERIAL_SOC_PARAMS_SVH

`define SERIAL_BASE 32'h0000_0000
`define RAM_BASE    32'h0000_0400

`define RAM_WORDS   256

// Ring placement inside the RAM, in words.
`define RING_BASE   32
`define RING_WORDS  16

`endif

// File: design/serial_soc_pkg.sv
/*
 * Serial SoC package.
 * Bus word types, register selector and the engine and copier state enums.
 */
package serial_soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  strobe_t;

    // Selected by address bits 3:2.
    typedef enum logic [1:0] {
        CONTROL, STATUS, DIVISION, DATA
    } reg_sel_t;

    typedef enum logic [1:0] {
        IDLE, BUSY, DONE
    } engine_state_t;

    typedef enum logic [2:0] {
        WAIT_IRQ, READ_STATUS, READ_DATA, STORE, CLEAR
    } copier_state_t;

    typedef struct packed {
        logic rx_irq_enable;
        logic tx_irq_enable;
    } control_t;

    typedef struct packed {
        logic rx_event;
        logic tx_event;
    } status_t;

endpackage

// File: design/serial_bus_if.sv
/*
 * Serial bus link.
 * One master and one target with plain valid/ready strobes.
 */
interface serial_bus_if (
    input bit bus,
    input bit rst
);

    logic                    valid;
    serial_soc_pkg::word_t   address;
    serial_soc_pkg::strobe_t wstrobe; // Non-zero means write.
    serial_soc_pkg::word_t   wdata;
    serial_soc_pkg::word_t   rdata;
    logic                    ready;

    modport master (
        input  bus,
        input  rst,
        output valid,
        output address,
        output wstrobe,
        output wdata,
        input  rdata,
        input  ready
    );

    modport target (
        input  bus,
        input  rst,
        input  valid,
        input  address,
        input  wstrobe,
        input  wdata,
        output rdata,
        output ready
    );

endinterface

// File: design/bus_fabric.sv
/*
 * Bus fabric.
 * Round-robin arbitration between host and copier, then decode
 * of the granted request onto the serial port or the scratch RAM.
 */
`include "serial_soc_params.svh"

module bus_fabric (
    serial_bus_if.target host,
    serial_bus_if.target copier,
    serial_bus_if.master port,
    serial_bus_if.master ram
);

    localparam serial_soc_pkg::word_t SERIAL_BASE = `SERIAL_BASE;
    localparam serial_soc_pkg::word_t RAM_BASE    = `RAM_BASE;

    logic                    grant_host;
    logic                    grant_copier;
    logic                    last_copier;
    logic                    sel_valid;
    serial_soc_pkg::word_t   sel_address;
    serial_soc_pkg::strobe_t sel_wstrobe;
    serial_soc_pkg::word_t   sel_wdata;
    logic [1:0]              region;
    serial_soc_pkg::word_t   resp_rdata;
    logic                    resp_ready;

    // Last granted master loses a tie.
    assign grant_host   = host.valid && (!copier.valid || last_copier);
    assign grant_copier = copier.valid && !grant_host;

    always_ff @(posedge host.bus) begin
        if (host.rst) begin
            last_copier <= 1'b0;
        end else if (grant_host || grant_copier) begin
            last_copier <= grant_copier;
        end
    end

    always_comb begin
        if (grant_copier) begin
            sel_address = copier.address;
            sel_wstrobe = copier.wstrobe;
            sel_wdata   = copier.wdata;
        end else begin
            sel_address = host.address;
            sel_wstrobe = host.wstrobe;
            sel_wdata   = host.wdata;
        end
    end

    assign sel_valid = grant_host || grant_copier;
    assign region    = sel_address[11:10];

    assign port.valid   = sel_valid && region == SERIAL_BASE[11:10];
    assign port.address = sel_address;
    assign port.wstrobe = sel_wstrobe;
    assign port.wdata   = sel_wdata;

    assign ram.valid    = sel_valid && region == RAM_BASE[11:10];
    assign ram.address  = sel_address;
    assign ram.wstrobe  = sel_wstrobe;
    assign ram.wdata    = sel_wdata;

    always_comb begin
        if (region == SERIAL_BASE[11:10]) begin
            resp_rdata = port.rdata;
            resp_ready = port.ready;
        end else if (region == RAM_BASE[11:10]) begin
            resp_rdata = ram.rdata;
            resp_ready = ram.ready;
        end else begin
            resp_rdata = '0; // Unmapped region.
            resp_ready = 1'b1;
        end
    end

    assign host.ready   = grant_host && resp_ready;
    assign host.rdata   = grant_host ? resp_rdata : '0;
    assign copier.ready = grant_copier && resp_ready;
    assign copier.rdata = grant_copier ? resp_rdata : '0;

endmodule

// File: design/serial_port.sv
/*
 * Serial port.
 * 8N1 transmitter and receiver with control, status, division
 * and data registers, and an interrupt on enabled events.
 */
module serial_port (
    serial_bus_if.target link,
    input  bit           rx,
    output bit           tx,
    output bit           irq
);

    localparam int BITS_PER_FRAME = 10; // Start, 8 data, stop.
    localparam int BIT_INDEX_MAX  = BITS_PER_FRAME - 1;

    serial_soc_pkg::reg_sel_t      sel;
    logic                          reg_write;
    logic [1:0]                    status_clear;
    logic [1:0]                    status_set;
    logic                          tx_start;
    serial_soc_pkg::control_t      control;
    serial_soc_pkg::status_t       status;
    serial_soc_pkg::word_t         division;
    serial_soc_pkg::byte_t         rx_data;

    serial_soc_pkg::engine_state_t tx_state;
    serial_soc_pkg::word_t         tx_count;
    logic [3:0]                    tx_index;
    serial_soc_pkg::byte_t         tx_shift;

    serial_soc_pkg::engine_state_t rx_state;
    serial_soc_pkg::word_t         rx_count;
    logic [3:0]                    rx_index;
    serial_soc_pkg::byte_t         rx_shift;

    function automatic serial_soc_pkg::word_t merge_bytes(
        serial_soc_pkg::word_t   old_value,
        serial_soc_pkg::word_t   new_value,
        serial_soc_pkg::strobe_t strobe
    );
        serial_soc_pkg::word_t result;
        result = old_value;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                result[8*i +: 8] = new_value[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign sel       = serial_soc_pkg::reg_sel_t'(link.address[3:2]);
    assign reg_write = link.valid && link.ready && |link.wstrobe;
    assign tx_start  = reg_write && sel == serial_soc_pkg::DATA && link.wstrobe[0];

    assign status_clear = (reg_write && sel == serial_soc_pkg::STATUS && link.wstrobe[0])
                        ? link.wdata[1:0] : 2'b00;
    assign status_set   = {rx_state == serial_soc_pkg::DONE, tx_state == serial_soc_pkg::DONE};

    always_ff @(posedge link.bus) begin
        if (link.rst) begin
            control  <= '0;
            status   <= '0;
            division <= '0;
        end else begin
            if (reg_write && sel == serial_soc_pkg::CONTROL && link.wstrobe[0]) begin
                control <= serial_soc_pkg::control_t'(link.wdata[1:0]);
            end
            if (reg_write && sel == serial_soc_pkg::DIVISION) begin
                division <= merge_bytes(division, link.wdata, link.wstrobe);
            end
            // A new event wins over a clear in the same cycle.
            status <= serial_soc_pkg::status_t'((status & ~status_clear) | status_set);
        end
    end

    always_ff @(posedge link.bus) begin
        if (link.rst) begin
            tx_state <= serial_soc_pkg::IDLE;
            tx       <= 1'b1;
            tx_count <= '0;
            tx_index <= '0;
            tx_shift <= '0;
        end else begin
            case (tx_state)
                serial_soc_pkg::IDLE: begin
                    if (tx_start) begin
                        tx_state <= serial_soc_pkg::BUSY;
                        tx_count <= division;
                        tx_index <= 4'(BIT_INDEX_MAX);
                        tx_shift <= link.wdata[7:0];
                        tx       <= 1'b0; // Start bit.
                    end
                end
                serial_soc_pkg::BUSY: begin
                    if (tx_count != 0) begin
                        tx_count <= tx_count - 1;
                    end else if (tx_index != 0) begin
                        tx_count      <= division;
                        tx            <= tx_index == 1 || tx_shift[0];
                        tx_shift[6:0] <= tx_shift[7:1];
                        tx_index      <= tx_index - 1;
                    end else begin
                        tx_state <= serial_soc_pkg::DONE;
                    end
                end
                default: begin
                    tx_state <= serial_soc_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge link.bus) begin
        if (link.rst) begin
            rx_state <= serial_soc_pkg::IDLE;
            rx_data  <= '0;
            rx_count <= '0;
            rx_index <= '0;
            rx_shift <= '0;
        end else begin
            case (rx_state)
                serial_soc_pkg::IDLE: begin
                    if (!rx) begin
                        rx_state <= serial_soc_pkg::BUSY;
                        rx_count <= division;
                        rx_index <= 4'(BIT_INDEX_MAX);
                    end
                end
                serial_soc_pkg::BUSY: begin
                    if (rx_index != 0) begin
                        if (rx_count == division / 2) begin
                            rx_shift <= {rx, rx_shift[7:1]}; // Mid-bit sample.
                        end
                        if (rx_count != 0) begin
                            rx_count <= rx_count - 1;
                        end else begin
                            rx_count <= division;
                            rx_index <= rx_index - 1;
                        end
                    end else if (rx) begin
                        rx_data  <= rx_shift;
                        rx_state <= serial_soc_pkg::DONE;
                    end
                end
                default: begin
                    rx_state <= serial_soc_pkg::IDLE;
                end
            endcase
        end
    end

    always_comb begin
        case (sel)
            serial_soc_pkg::CONTROL:  link.rdata = serial_soc_pkg::word_t'(control);
            serial_soc_pkg::STATUS:   link.rdata = serial_soc_pkg::word_t'(status);
            serial_soc_pkg::DIVISION: link.rdata = division;
            default:                  link.rdata = serial_soc_pkg::word_t'(rx_data);
        endcase
    end

    assign link.ready = 1'b1;
    assign irq = control.tx_irq_enable && status.tx_event
              || control.rx_irq_enable && status.rx_event;

endmodule

// File: design/scratch_ram.sv
/*
 * Scratch RAM.
 * Single-port word array with byte-strobed writes and combinational reads.
 */
`include "serial_soc_params.svh"

module scratch_ram (
    serial_bus_if.target link
);

    localparam int INDEX_WIDTH = $clog2(`RAM_WORDS);

    serial_soc_pkg::word_t  mem [`RAM_WORDS];
    logic [INDEX_WIDTH-1:0] index;

    assign index = link.address[2 +: INDEX_WIDTH]; // Word index.

    always_ff @(posedge link.bus) begin
        if (link.valid) begin
            for (int i = 0; i < 4; i++) begin
                if (link.wstrobe[i]) begin
                    mem[index][8*i +: 8] <= link.wdata[8*i +: 8];
                end
            end
        end
    end

    assign link.rdata = mem[index];
    assign link.ready = 1'b1;

endmodule

// File: design/rx_copier.sv
/*
 * Receive copier.
 * Bus master that moves each received byte into a RAM ring on interrupt.
 */
`include "serial_soc_params.svh"

module rx_copier (
    serial_bus_if.master link,
    input bit            irq
);

    localparam serial_soc_pkg::word_t STATUS_ADDR =
        `SERIAL_BASE + (serial_soc_pkg::word_t'(serial_soc_pkg::STATUS) << 2);
    localparam serial_soc_pkg::word_t DATA_ADDR =
        `SERIAL_BASE + (serial_soc_pkg::word_t'(serial_soc_pkg::DATA) << 2);
    localparam serial_soc_pkg::status_t RX_CLEAR = '{rx_event: 1'b1, tx_event: 1'b0};

    serial_soc_pkg::copier_state_t     state;
    serial_soc_pkg::status_t           seen;
    serial_soc_pkg::byte_t             rx_byte;
    logic [$clog2(`RING_WORDS)-1:0]    write_index;
    serial_soc_pkg::word_t             ring_address;

    assign seen         = serial_soc_pkg::status_t'(link.rdata[1:0]);
    assign ring_address = `RAM_BASE
                        + ((`RING_BASE + serial_soc_pkg::word_t'(write_index)) << 2);

    always_ff @(posedge link.bus) begin
        if (link.rst) begin
            state       <= serial_soc_pkg::WAIT_IRQ;
            write_index <= '0;
            rx_byte     <= '0;
        end else begin
            case (state)
                serial_soc_pkg::WAIT_IRQ: begin
                    if (irq) state <= serial_soc_pkg::READ_STATUS;
                end
                serial_soc_pkg::READ_STATUS: begin
                    if (link.ready) begin
                        // Tx events stay with the host.
                        state <= seen.rx_event ? serial_soc_pkg::READ_DATA
                                               : serial_soc_pkg::WAIT_IRQ;
                    end
                end
                serial_soc_pkg::READ_DATA: begin
                    if (link.ready) begin
                        rx_byte <= link.rdata[7:0];
                        state   <= serial_soc_pkg::STORE;
                    end
                end
                serial_soc_pkg::STORE: begin
                    if (link.ready) begin
                        write_index <= write_index + 1'b1; // Wraps at ring end.
                        state       <= serial_soc_pkg::CLEAR;
                    end
                end
                default: begin
                    if (link.ready) state <= serial_soc_pkg::WAIT_IRQ;
                end
            endcase
        end
    end

    always_comb begin
        link.valid   = 1'b1;
        link.address = STATUS_ADDR;
        link.wstrobe = '0;
        link.wdata   = '0;
        case (state)
            serial_soc_pkg::WAIT_IRQ:  link.valid = 1'b0;
            serial_soc_pkg::READ_DATA: link.address = DATA_ADDR;
            serial_soc_pkg::STORE: begin
                link.address = ring_address;
                link.wstrobe = 4'hF;
                link.wdata   = serial_soc_pkg::word_t'(rx_byte);
            end
            serial_soc_pkg::CLEAR: begin
                link.wstrobe = 4'b0001; // Write-one-to-clear rx_event.
                link.wdata   = serial_soc_pkg::word_t'(RX_CLEAR);
            end
            default: ;
        endcase
    end

endmodule

// File: design/serial_soc.sv
/*
 * Serial SoC top level.
 * Host bus ports, arbitrated fabric, serial port, scratch RAM and receive copier.
 */
module serial_soc (
    input  bit                      bus,
    input  bit                      rst,
    input  bit                      host_valid,
    input  serial_soc_pkg::word_t   host_address,
    input  serial_soc_pkg::strobe_t host_wstrobe,
    input  serial_soc_pkg::word_t   host_wdata,
    output serial_soc_pkg::word_t   host_rdata,
    output bit                      host_ready,
    input  bit                      rx,
    output bit                      tx,
    output bit                      irq
);

    serial_bus_if host_link   (.bus(bus), .rst(rst));
    serial_bus_if copier_link (.bus(bus), .rst(rst));
    serial_bus_if port_link   (.bus(bus), .rst(rst));
    serial_bus_if ram_link    (.bus(bus), .rst(rst));

    assign host_link.valid   = host_valid;
    assign host_link.address = host_address;
    assign host_link.wstrobe = host_wstrobe;
    assign host_link.wdata   = host_wdata;
    assign host_rdata        = host_link.rdata;
    assign host_ready        = host_link.ready;

    bus_fabric fabric (
        .host   (host_link),
        .copier (copier_link),
        .port   (port_link),
        .ram    (ram_link)
    );

    serial_port port (
        .link (port_link),
        .rx   (rx),
        .tx   (tx),
        .irq  (irq)
    );

    scratch_ram ram (
        .link (ram_link)
    );

    rx_copier copier (
        .link (copier_link),
        .irq  (irq) // Shared with the top-level interrupt.
    );

endmodule

// File: bench/tb_clock.sv
/*
 * Testbench clock source.
 */
module tb_clock #(
    parameter int PERIOD = 100
) (
    output bit bus
);

    always #(PERIOD / 2) bus = ~bus;

endmodule

// File: bench/serial_soc_chk.sv
/*
 * Bus and serial port checker.
 * Grant exclusivity, idle line level and transmit event timing.
 */
module serial_soc_chk (
    input bit                            bus,
    input bit                            rst,
    input logic                          grant_host,
    input logic                          grant_copier,
    input serial_soc_pkg::engine_state_t tx_state,
    input bit                            tx,
    input serial_soc_pkg::status_t       status
);

    int failures = 0;

    one_grant: assert property (@(posedge bus) disable iff (rst)
        !(grant_host && grant_copier))
        else begin $error("both masters granted"); failures++; end

    idle_line: assert property (@(posedge bus) disable iff (rst)
        tx_state == serial_soc_pkg::IDLE |-> tx)
        else begin $error("tx low while transmitter idle"); failures++; end

    tx_event_set: assert property (@(posedge bus) disable iff (rst)
        tx_state == serial_soc_pkg::DONE |=> status.tx_event)
        else begin $error("tx_event not set after frame end"); failures++; end

endmodule

bind serial_soc serial_soc_chk soc_chk (
    .bus(bus), .rst(rst),
    .grant_host(fabric.grant_host), .grant_copier(fabric.grant_copier),
    .tx_state(port.tx_state), .tx(tx), .status(port.status)
);

// File: bench/serial_soc_tb.sv
/*
 * Serial SoC testbench.
 * Directed tests for registers, transmit, receive copy and bus contention.
 */
`include "serial_soc_params.svh"

module serial_soc_tb;

    localparam int PERIOD          = 100;
    localparam int FRAME_CYCLES    = 60;   // Ten bits at division 3 plus copy.
    localparam int FRAMES          = 26;
    localparam int WATCHDOG_CYCLES = FRAMES * FRAME_CYCLES + 4000;
    localparam serial_soc_pkg::word_t CONTROL_ADDR  = `SERIAL_BASE;
    localparam serial_soc_pkg::word_t STATUS_ADDR   = `SERIAL_BASE + 4;
    localparam serial_soc_pkg::word_t DIVISION_ADDR = `SERIAL_BASE + 8;
    localparam serial_soc_pkg::word_t DATA_ADDR     = `SERIAL_BASE + 12;

    bit                      bus;
    bit                      rst;
    bit                      host_valid;
    serial_soc_pkg::word_t   host_address;
    serial_soc_pkg::strobe_t host_wstrobe;
    serial_soc_pkg::word_t   host_wdata;
    serial_soc_pkg::word_t   host_rdata;
    bit                      host_ready;
    bit                      rx;
    bit                      tx;
    bit                      irq;

    logic [31:0]             lfsr = 32'h5529fb3e;
    string                   test_name;
    int                      test_errors;
    int                      errors;
    int                      tests_run;
    int                      tests_failed;
    int                      assert_failures;
    serial_soc_pkg::byte_t   ring_expect [`RING_WORDS];
    int                      ring_next;
    bit                      frames_done;

    tb_clock #(.PERIOD(PERIOD)) clock_gen (.bus(bus));

    serial_soc uut (
        .bus(bus), .rst(rst), .host_valid(host_valid), .host_address(host_address),
        .host_wstrobe(host_wstrobe), .host_wdata(host_wdata), .host_rdata(host_rdata),
        .host_ready(host_ready), .rx(rx), .tx(tx), .irq(irq)
    );

    function automatic logic [31:0] lfsr_shift(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // Taps 32,22,2,1.
    endfunction

    function automatic serial_soc_pkg::word_t ram_word_address(input int index);
        return `RAM_BASE + serial_soc_pkg::word_t'(index * 4);
    endfunction

    function automatic serial_soc_pkg::word_t fill_pattern(input serial_soc_pkg::word_t address);
        return address ^ {address[15:0], address[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    task automatic random_byte(output serial_soc_pkg::byte_t value);
        for (int i = 0; i < 8; i++) begin
            lfsr  = lfsr_shift(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_condition(input bit condition, input string message);
        assert (condition) else begin
            $display("%s: %s", test_name, message);
            test_errors++;
        end
    endtask

    task automatic host_access(input serial_soc_pkg::word_t address,
                               input serial_soc_pkg::strobe_t strobe,
                               input serial_soc_pkg::word_t data,
                               output serial_soc_pkg::word_t rdata);
        int cycles;
        @(posedge bus);
        host_valid   <= 1'b1;
        host_address <= address;
        host_wstrobe <= strobe;
        host_wdata   <= data;
        cycles = 0;
        do begin
            @(negedge bus);
            cycles++;
        end while (!host_ready && cycles < 20);
        check_condition(host_ready, $sformatf("no ready for host transfer to %h", address));
        rdata = host_rdata;
        @(posedge bus); // Transfer completes here.
        host_valid <= 1'b0;
    endtask

    task automatic host_write(input serial_soc_pkg::word_t address,
                              input serial_soc_pkg::strobe_t strobe,
                              input serial_soc_pkg::word_t data);
        serial_soc_pkg::word_t unused;
        host_access(address, strobe, data, unused);
    endtask

    task automatic host_read(input serial_soc_pkg::word_t address,
                             output serial_soc_pkg::word_t data);
        host_access(address, 4'h0, '0, data);
    endtask

    task automatic wait_irq(input bit level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge bus);
            cycles++;
        end while (irq != level && cycles < 100);
        check_condition(irq == level, $sformatf("irq never went to %0b", level));
    endtask

    task automatic send_frame(input serial_soc_pkg::byte_t value, input int bit_cycles);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0}; // Stop, data LSB first, start.
        for (int i = 0; i < 10; i++) begin
            @(posedge bus);
            rx <= frame[i];
            repeat (bit_cycles - 1) @(posedge bus);
        end
    endtask

    // One received byte, copied into the next ring word.
    task automatic deliver_byte();
        serial_soc_pkg::byte_t value;
        random_byte(value);
        ring_expect[ring_next] = value;
        ring_next = (ring_next + 1) % `RING_WORDS;
        send_frame(value, 4);
        wait_irq(1'b1);
        wait_irq(1'b0);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end else begin
            $display("%s: passed", test_name);
        end
    endtask

    task automatic test_reset();
        serial_soc_pkg::word_t data;
        begin_test("reset");
        host_read(CONTROL_ADDR, data);
        check_value("control", 32'h0, data);
        host_read(STATUS_ADDR, data);
        check_value("status", 32'h0, data);
        host_read(DIVISION_ADDR, data);
        check_value("division", 32'h0, data);
        @(negedge bus);
        check_value("tx", 32'h1, {31'b0, tx});
        check_value("irq", 32'h0, {31'b0, irq});
        end_test();
    endtask

    task automatic test_registers();
        serial_soc_pkg::word_t data;
        serial_soc_pkg::byte_t value;
        int polls;
        begin_test("registers");
        host_write(DIVISION_ADDR, 4'hF, 32'h1234_5678);
        host_write(DIVISION_ADDR, 4'b0101, 32'hAABB_CCDD);
        host_read(DIVISION_ADDR, data);
        check_value("division", 32'h12BB_56DD, data);
        host_write(DIVISION_ADDR, 4'hF, 32'd1);
        random_byte(value);
        host_write(DATA_ADDR, 4'h1, serial_soc_pkg::word_t'(value));
        send_frame(value, 2);
        polls = 0;
        do begin
            host_read(STATUS_ADDR, data);
            polls++;
        end while (data != 32'h3 && polls < 20);
        check_value("both flags", 32'h3, data);
        host_write(STATUS_ADDR, 4'h1, 32'h1);
        host_read(STATUS_ADDR, data);
        check_value("tx_event cleared", 32'h2, data);
        host_write(STATUS_ADDR, 4'h1, 32'h2);
        host_read(STATUS_ADDR, data);
        check_value("rx_event cleared", 32'h0, data);
        end_test();
    endtask

    task automatic test_transmit();
        serial_soc_pkg::byte_t value;
        logic [9:0] frame;
        begin_test("transmit");
        host_write(DIVISION_ADDR, 4'hF, 32'd3);
        host_write(CONTROL_ADDR, 4'h1, 32'h1);
        for (int n = 0; n < 6; n++) begin
            random_byte(value);
            frame = {1'b1, value, 1'b0};
            host_write(DATA_ADDR, 4'h1, serial_soc_pkg::word_t'(value));
            for (int i = 0; i < 10; i++) begin
                repeat ((i == 0) ? 3 : 4) @(negedge bus); // Mid-bit.
                check_value($sformatf("byte %0d bit %0d", n, i), {31'b0, frame[i]}, {31'b0, tx});
            end
            wait_irq(1'b1);
            host_write(STATUS_ADDR, 4'h1, 32'h1);
            @(negedge bus);
            check_value("irq after clear", 32'h0, {31'b0, irq});
        end
        end_test();
    endtask

    task automatic test_receive();
        serial_soc_pkg::word_t data;
        begin_test("receive");
        host_write(CONTROL_ADDR, 4'h1, 32'h2);
        repeat (5) deliver_byte();
        for (int i = 0; i < 5; i++) begin
            host_read(ram_word_address(`RING_BASE + i), data);
            check_value($sformatf("ring %0d", i), {24'b0, ring_expect[i]}, data);
        end
        host_read(STATUS_ADDR, data);
        check_value("rx_event", 32'h0, {31'b0, data[1]});
        end_test();
    endtask

    task automatic test_contention();
        serial_soc_pkg::word_t data;
        int k;
        begin_test("contention");
        for (int i = 0; i < 16; i++) begin
            host_write(ram_word_address(i), 4'hF, fill_pattern(ram_word_address(i)));
        end
        frames_done = 1'b0;
        fork
            begin
                repeat (14) deliver_byte(); // Wraps past the ring end.
                frames_done = 1'b1;
            end
            begin
                k = 0;
                while (!frames_done) begin
                    host_read(ram_word_address(k), data);
                    check_value($sformatf("word %0d", k), fill_pattern(ram_word_address(k)), data);
                    k = (k + 1) % 16;
                end
            end
        join
        for (int i = 0; i < `RING_WORDS; i++) begin
            host_read(ram_word_address(`RING_BASE + i), data);
            check_value($sformatf("ring %0d", i), {24'b0, ring_expect[i]}, data);
        end
        end_test();
    endtask

    initial begin
        rst          = 1'b1;
        host_valid   = 1'b0;
        host_address = '0;
        host_wstrobe = '0;
        host_wdata   = '0;
        rx           = 1'b1;
        repeat (5) @(posedge bus);
        rst <= 1'b0;
        test_reset();
        test_registers();
        test_transmit();
        test_receive();
        test_contention();
        assert_failures = uut.soc_chk.failures;
        $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
                 tests_run, tests_failed, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: serial_soc.f
+incdir+design
design/serial_soc_pkg.sv
design/serial_bus_if.sv
design/bus_fabric.sv
design/serial_port.sv
design/scratch_ram.sv
design/rx_copier.sv
design/serial_soc.sv
bench/tb_clock.sv
bench/serial_soc_chk.sv
bench/serial_soc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= serial_soc_tb
FILELIST  ?= serial_soc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q 'Test failures found' $(LOG) || ! grep -q 'All tests passed!' $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
